/* build.f */
src/expand_pkg.sv
src/expand_weight_rom.sv
src/expand_mac.sv
src/expand_sequencer.sv
src/expand_requant.sv
src/fire_expand3.sv
testbench/tb_fire_expand3.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fire_expand3 testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing \
	-f build.f \
	--top-module tb_fire_expand3 \
	-o sim_fire_expand3

./obj_dir/sim_fire_expand3 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi

echo "Simulation passed"

/* src/expand_mac.sv */
`timescale 1ns/1ps

module expand_mac (
	input  logic               clk,
	input  logic               rst_gen,
	input  logic               valid_i,
	input  logic               first_i,
	input  expand_pkg::pix_t   pix_i,
	input  expand_pkg::pix_t   weight_i,
	output expand_pkg::acc_t   acc_o
);

	expand_pkg::acc_t product;

	// Full signed product
	// Operands widen to the accumulator before the multiply
	assign product = pix_i * weight_i;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			acc_o <= '0;
		end else if (valid_i) begin
			// First tap starts a new pixel
			if (first_i) begin
				acc_o <= product;
			end else begin
				acc_o <= acc_o + product;
			end
		end
		// Gap cycle holds the partial sum
	end

endmodule

/* src/expand_pkg.sv */
package expand_pkg;

	//////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////

	// Data widths
	localparam int PIX_W = 16;
	localparam int ACC_W = 32;
	// One lane per output channel
	localparam int NUM_MAC = 8;
	localparam int CHIN = 4;
	localparam int KERNEL_DIM = 3;
	// Taps per output pixel, kernel position major
	localparam int TAPS = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int TAP_W = $clog2(TAPS);
	localparam int OUT_PIX = 16;
	// Counter must be able to hold OUT_PIX itself
	localparam int PIX_CNT_W = $clog2(OUT_PIX + 1);
	localparam int Q_SHIFT = 8;
	// fire2 and fire3
	localparam int NUM_LAYERS = 2;

	//////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////

	typedef logic signed [PIX_W-1:0] pix_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [TAP_W-1:0] tap_idx_t;
	// 0 is fire2, 1 is fire3
	typedef logic layer_t;

	typedef pix_t [NUM_MAC-1:0] weight_vec_t;
	typedef acc_t [NUM_MAC-1:0] bias_vec_t;
	typedef acc_t [NUM_MAC-1:0] acc_vec_t;
	typedef pix_t [NUM_MAC-1:0] ofm_vec_t;

	// Per-tap control word
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		layer_t layer;
		tap_idx_t tap;
	} tap_ctrl_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_END
	} seq_state_t;

	// Compare values
	localparam tap_idx_t TAP_LAST = tap_idx_t'(TAPS - 1);
	localparam logic [PIX_CNT_W-1:0] PIX_LAST = PIX_CNT_W'(OUT_PIX - 1);
	localparam acc_t SAT_MAX = acc_t'(32'sh0000_7FFF);

	//////////////////////////////////////////////////////////////
	// Table rules
	//////////////////////////////////////////////////////////////

	// Small signed weights in -8..8
	function automatic pix_t weight_rule(input layer_t layer, input int tap, input int ch);
		int v;
		v = ((tap * 3) + (ch * 5) + (int'(layer) * 7)) % 17 - 8;
		return pix_t'(v);
	endfunction

	// Bias grows with channel, fire3 offset upward
	function automatic acc_t bias_rule(input layer_t layer, input int ch);
		int v;
		v = (ch * 96) - 300 + (int'(layer) * 150);
		return acc_t'(v);
	endfunction

endpackage

/* src/expand_requant.sv */
`timescale 1ns/1ps

module expand_requant (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  expand_pkg::acc_vec_t  acc_i,
	input  expand_pkg::bias_vec_t bias_i,
	input  logic                  last_i,
	output expand_pkg::ofm_vec_t  ofm_o,
	output logic                  ofm_valid_o
);

	expand_pkg::acc_t sum_w [expand_pkg::NUM_MAC];
	expand_pkg::acc_t shift_w [expand_pkg::NUM_MAC];
	expand_pkg::ofm_vec_t q_w;

	//////////////////////////////////////////////////////////////
	// Bias, ReLU, shift, saturate
	//////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < expand_pkg::NUM_MAC; i++) begin
			sum_w[i] = acc_i[i] + bias_i[i];
			shift_w[i] = sum_w[i] >>> expand_pkg::Q_SHIFT;
			// ReLU on the sign bit
			if (sum_w[i][expand_pkg::ACC_W-1]) begin
				q_w[i] = '0;
			end else if (shift_w[i] > expand_pkg::SAT_MAX) begin
				// Clip to largest positive word
				q_w[i] = expand_pkg::pix_t'(expand_pkg::SAT_MAX);
			end else begin
				q_w[i] = shift_w[i][expand_pkg::PIX_W-1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////

	// Word changes only on a finished pixel
	always_ff @(posedge clk) begin
		if (last_i) begin
			ofm_o <= q_w;
		end
	end

	// One-cycle sample strobe
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			ofm_valid_o <= 1'b0;
		end else begin
			ofm_valid_o <= last_i;
		end
	end

endmodule

/* src/expand_sequencer.sv */
`timescale 1ns/1ps

module expand_sequencer (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  logic                  fire2_en_i,
	input  logic                  fire3_en_i,
	input  logic                  ram_ack2_i,
	input  logic                  ram_ack3_i,
	output expand_pkg::tap_ctrl_t tap_o,
	output logic                  finish2_o,
	output logic                  finish3_o
);

	// Index 0 is fire2, index 1 is fire3
	logic [expand_pkg::NUM_LAYERS-1:0] en_req;
	logic [expand_pkg::NUM_LAYERS-1:0] ack_req;
	logic [expand_pkg::NUM_LAYERS-1:0] en_ok;
	logic [expand_pkg::NUM_LAYERS-1:0] sel;
	logic [expand_pkg::NUM_LAYERS-1:0] ack_q;
	logic go;
	expand_pkg::layer_t layer_sel;
	logic tap_first;
	logic tap_last;
	expand_pkg::tap_idx_t tap_cnt_q;
	expand_pkg::seq_state_t state_q [expand_pkg::NUM_LAYERS];
	expand_pkg::seq_state_t state_d [expand_pkg::NUM_LAYERS];
	logic [expand_pkg::PIX_CNT_W-1:0] pix_cnt_q [expand_pkg::NUM_LAYERS];

	assign en_req = {fire3_en_i, fire2_en_i};
	assign ack_req = {ram_ack3_i, ram_ack2_i};

	//////////////////////////////////////////////////////////////
	// Layer select
	//////////////////////////////////////////////////////////////

	// Finished layer ignores its enable
	always_comb begin
		for (int l = 0; l < expand_pkg::NUM_LAYERS; l++) begin
			en_ok[l] = en_req[l] && (state_q[l] != expand_pkg::SEQ_END);
		end
	end

	// fire2 wins when both ask
	assign sel[0] = en_ok[0];
	assign sel[1] = en_ok[1] && !en_ok[0];
	assign go = |sel;
	assign layer_sel = sel[1];

	// Tap position within the pixel
	assign tap_first = (tap_cnt_q == '0);
	assign tap_last = (tap_cnt_q == expand_pkg::TAP_LAST);

	//////////////////////////////////////////////////////////////
	// Per-layer FSM
	//////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < expand_pkg::NUM_LAYERS; l++) begin
			state_d[l] = state_q[l];
			case (state_q[l])
				expand_pkg::SEQ_IDLE: begin
					if (sel[l]) begin
						state_d[l] = expand_pkg::SEQ_RUN;
					end
				end
				expand_pkg::SEQ_RUN: begin
					// Last tap of the last pixel
					if (sel[l] && tap_last && (pix_cnt_q[l] == expand_pkg::PIX_LAST)) begin
						state_d[l] = expand_pkg::SEQ_END;
					end
				end
				// Held until reset
				expand_pkg::SEQ_END: state_d[l] = expand_pkg::SEQ_END;
				default: state_d[l] = expand_pkg::SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			for (int l = 0; l < expand_pkg::NUM_LAYERS; l++) begin
				state_q[l] <= expand_pkg::SEQ_IDLE;
				pix_cnt_q[l] <= '0;
			end
			ack_q <= '0;
		end else begin
			for (int l = 0; l < expand_pkg::NUM_LAYERS; l++) begin
				state_q[l] <= state_d[l];
				// One count per finished pixel
				if (sel[l] && tap_last) begin
					pix_cnt_q[l] <= pix_cnt_q[l] + 1'b1;
				end
				// Ack only counts once the layer is done
				if ((state_q[l] == expand_pkg::SEQ_END) && ack_req[l]) begin
					ack_q[l] <= 1'b1;
				end
			end
		end
	end

	// Finish level from end latch until acked
	assign finish2_o = (state_q[0] == expand_pkg::SEQ_END) && !ack_q[0];
	assign finish3_o = (state_q[1] == expand_pkg::SEQ_END) && !ack_q[1];

	//////////////////////////////////////////////////////////////
	// Tap counter and control word
	//////////////////////////////////////////////////////////////

	// Wraps straight into the next pixel, no gap cycle
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			tap_cnt_q <= '0;
		end else if (go) begin
			if (tap_last) begin
				tap_cnt_q <= '0;
			end else begin
				tap_cnt_q <= tap_cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			tap_o <= '0;
		end else begin
			tap_o.valid <= go;
			tap_o.first <= tap_first;
			tap_o.last <= tap_last;
			tap_o.layer <= layer_sel;
			tap_o.tap <= tap_cnt_q;
		end
	end

endmodule

/* src/expand_weight_rom.sv */
`timescale 1ns/1ps

module expand_weight_rom (
	input  logic                    clk,
	input  expand_pkg::tap_ctrl_t   tap_i,
	output expand_pkg::weight_vec_t weights_o,
	output expand_pkg::bias_vec_t   bias_o
);

	// One word holds the weights of all lanes for one tap
	function automatic expand_pkg::weight_vec_t weight_word(input int layer, input int tap);
		expand_pkg::weight_vec_t word;
		for (int c = 0; c < expand_pkg::NUM_MAC; c++) begin
			word[c] = expand_pkg::weight_rule(expand_pkg::layer_t'(layer), tap, c);
		end
		return word;
	endfunction

	// Bias word per layer
	function automatic expand_pkg::bias_vec_t bias_word(input int layer);
		expand_pkg::bias_vec_t word;
		for (int c = 0; c < expand_pkg::NUM_MAC; c++) begin
			word[c] = expand_pkg::bias_rule(expand_pkg::layer_t'(layer), c);
		end
		return word;
	endfunction

	//////////////////////////////////////////////////////////////
	// Tables
	//////////////////////////////////////////////////////////////

	expand_pkg::weight_vec_t w_tab [expand_pkg::NUM_LAYERS][expand_pkg::TAPS];
	expand_pkg::bias_vec_t b_tab [expand_pkg::NUM_LAYERS];

	// Constant contents, resolved at elaboration
	for (genvar l = 0; l < expand_pkg::NUM_LAYERS; l++) begin : g_layer
		assign b_tab[l] = bias_word(l);
		for (genvar t = 0; t < expand_pkg::TAPS; t++) begin : g_tap
			assign w_tab[l][t] = weight_word(l, t);
		end
	end

	//////////////////////////////////////////////////////////////
	// Registered read
	//////////////////////////////////////////////////////////////

	// Read only on a live tap
	// Idle cycles keep the last word
	always_ff @(posedge clk) begin
		if (tap_i.valid) begin
			weights_o <= w_tab[tap_i.layer][tap_i.tap];
			// Same bias for every tap of a layer
			bias_o <= b_tab[tap_i.layer];
		end
	end

endmodule

/* src/fire_expand3.sv */
`timescale 1ns/1ps

module fire_expand3 (
	input  logic                 clk,
	input  logic                 rst_gen,
	input  logic                 fire2_en_i,
	input  logic                 fire3_en_i,
	input  logic                 ram_ack2_i,
	input  logic                 ram_ack3_i,
	input  expand_pkg::pix_t     pix_i,
	output expand_pkg::ofm_vec_t ofm_o,
	output logic                 ofm_valid_o,
	output logic                 finish2_o,
	output logic                 finish3_o
);

	logic fire2_en_q;
	logic fire3_en_q;
	expand_pkg::pix_t pix_q;
	expand_pkg::pix_t pix_s1;
	expand_pkg::pix_t pix_al;
	expand_pkg::tap_ctrl_t tap_ctrl;
	expand_pkg::tap_ctrl_t ctrl_al;
	expand_pkg::weight_vec_t weights;
	expand_pkg::bias_vec_t bias_rom;
	expand_pkg::bias_vec_t bias_q;
	expand_pkg::acc_vec_t acc_vec;
	logic last_q;

	//////////////////////////////////////////////////////////////
	// Stage 0 input register
	//////////////////////////////////////////////////////////////

	// Acks go straight to the sequencer latches
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			fire2_en_q <= 1'b0;
			fire3_en_q <= 1'b0;
		end else begin
			fire2_en_q <= fire2_en_i;
			fire3_en_q <= fire3_en_i;
		end
	end

	// Pixel path, valid rides in the control word
	always_ff @(posedge clk) begin
		pix_q <= pix_i;
		// Beside the sequencer register
		pix_s1 <= pix_q;
		// Beside the ROM register
		pix_al <= pix_s1;
	end

	expand_sequencer u_seq (
		.clk        (clk),
		.rst_gen    (rst_gen),
		.fire2_en_i (fire2_en_q),
		.fire3_en_i (fire3_en_q),
		.ram_ack2_i (ram_ack2_i),
		.ram_ack3_i (ram_ack3_i),
		.tap_o      (tap_ctrl),
		.finish2_o  (finish2_o),
		.finish3_o  (finish3_o)
	);

	expand_weight_rom u_rom (
		.clk       (clk),
		.tap_i     (tap_ctrl),
		.weights_o (weights),
		.bias_o    (bias_rom)
	);

	//////////////////////////////////////////////////////////////
	// Alignment with ROM data
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			ctrl_al <= '0;
			last_q <= 1'b0;
		end else begin
			ctrl_al <= tap_ctrl;
			// Lane sums are complete one edge later
			last_q <= ctrl_al.valid && ctrl_al.last;
		end
	end

	// Bias captured with the last tap
	// Next pixel may already switch layer in the ROM
	always_ff @(posedge clk) begin
		if (ctrl_al.valid && ctrl_al.last) begin
			bias_q <= bias_rom;
		end
	end

	// One lane per output channel
	for (genvar i = 0; i < expand_pkg::NUM_MAC; i++) begin : g_lane
		expand_mac u_mac (
			.clk      (clk),
			.rst_gen  (rst_gen),
			.valid_i  (ctrl_al.valid),
			.first_i  (ctrl_al.first),
			.pix_i    (pix_al),
			.weight_i (weights[i]),
			.acc_o    (acc_vec[i])
		);
	end

	expand_requant u_requant (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.acc_i       (acc_vec),
		.bias_i      (bias_q),
		.last_i      (last_q),
		.ofm_o       (ofm_o),
		.ofm_valid_o (ofm_valid_o)
	);

endmodule

/* testbench/tb_fire_expand3.sv */
`timescale 1ns/1ps

module tb_fire_expand3;

	// Pixels sent over the whole run, extra and partial taps included
	localparam int TOTAL_TAPS = 69 * expand_pkg::TAPS + 3;
	// Room for one gap cycle per tap plus drain time
	localparam int WATCHDOG_CYCLES = 2 * TOTAL_TAPS + 200;

	logic clk = 1'b0;
	logic rst_gen = 1'b1;
	logic fire2_en = 1'b0;
	logic fire3_en = 1'b0;
	logic ram_ack2 = 1'b0;
	logic ram_ack3 = 1'b0;
	expand_pkg::pix_t pix = '0;
	expand_pkg::ofm_vec_t ofm;
	logic ofm_valid;
	logic finish2;
	logic finish3;

	logic [31:0] lfsr_q = 32'he4ea;
	expand_pkg::pix_t tap_buf [expand_pkg::TAPS];
	int tap_pos = 0;
	expand_pkg::ofm_vec_t exp_q [$];
	int value_errs = 0;
	int unexpected_errs = 0;
	int missing_errs = 0;

	fire_expand3 u_dut (
		.clk         (clk),
		.rst_gen     (rst_gen),
		.fire2_en_i  (fire2_en),
		.fire3_en_i  (fire3_en),
		.ram_ack2_i  (ram_ack2),
		.ram_ack3_i  (ram_ack3),
		.pix_i       (pix),
		.ofm_o       (ofm),
		.ofm_valid_o (ofm_valid),
		.finish2_o   (finish2),
		.finish3_o   (finish3)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////
	// Random source and reference model
	//////////////////////////////////////////////////////////////

	// Galois form, polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	// Weight (3t + 5c + 7l) mod 17 - 8, bias 96c - 300 + 150l
	function automatic expand_pkg::ofm_vec_t ref_ofm(input logic layer,
			input expand_pkg::pix_t px [expand_pkg::TAPS]);
		expand_pkg::ofm_vec_t res;
		int acc;
		int w;
		int sum;
		for (int c = 0; c < expand_pkg::NUM_MAC; c++) begin
			acc = 0;
			for (int t = 0; t < expand_pkg::TAPS; t++) begin
				w = ((t * 3 + c * 5 + int'(layer) * 7) % 17) - 8;
				acc += int'(px[t]) * w;
			end
			sum = acc + c * 96 - 300 + int'(layer) * 150;
			// ReLU, then shift by 8 and clip to the positive word range
			if (sum < 0) begin
				res[c] = '0;
			end else if ((sum >>> 8) > 32767) begin
				res[c] = 16'h7fff;
			end else begin
				res[c] = expand_pkg::pix_t'(sum >>> 8);
			end
		end
		return res;
	endfunction

	//////////////////////////////////////////////////////////////
	// Compare tasks and output monitor
	//////////////////////////////////////////////////////////////

	task automatic check_ofm(input string name, input expand_pkg::ofm_vec_t got,
			input expand_pkg::ofm_vec_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// Outputs settle between edges
	always @(negedge clk) begin
		if (ofm_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				unexpected_errs++;
				$display("Output word %h arrived while no pixel was pending", ofm);
			end else begin
				check_ofm("ofm_o", ofm, exp_q.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Stimulus tasks, each entered and left on a rising edge
	//////////////////////////////////////////////////////////////

	task automatic apply_reset();
		rst_gen <= 1'b1;
		fire2_en <= 1'b0;
		fire3_en <= 1'b0;
		ram_ack2 <= 1'b0;
		ram_ack3 <= 1'b0;
		// Words still in the pipeline are lost
		exp_q.delete();
		repeat (4) @(posedge clk);
		rst_gen <= 1'b0;
		// Partial pixel is dropped
		tap_pos = 0;
	endtask

	// Random gap of one or more cycles, one chance in four
	task automatic send_tap(input logic layer, input expand_pkg::pix_t px, input logic record);
		logic [31:0] r;
		take_bits(2, r);
		while (r[1:0] == 2'd0) begin
			fire2_en <= 1'b0;
			fire3_en <= 1'b0;
			@(posedge clk);
			take_bits(2, r);
		end
		fire2_en <= !layer;
		fire3_en <= layer;
		pix <= px;
		@(posedge clk);
		if (record) begin
			tap_buf[tap_pos] = px;
			tap_pos++;
			if (tap_pos == expand_pkg::TAPS) begin
				exp_q.push_back(ref_ofm(layer, tap_buf));
				tap_pos = 0;
			end
		end
	endtask

	// Pixels 12 and 13 large negative, 14 and 15 large positive
	task automatic run_layer(input logic layer, input int npix);
		logic [31:0] r;
		expand_pkg::pix_t px;
		for (int p = 0; p < npix; p++) begin
			for (int t = 0; t < expand_pkg::TAPS; t++) begin
				if (p >= 14) begin
					take_bits(14, r);
					px = expand_pkg::pix_t'(32767 - int'(r[13:0]));
				end else if (p >= 12) begin
					take_bits(14, r);
					px = expand_pkg::pix_t'(int'(r[13:0]) - 32768);
				end else begin
					take_bits(8, r);
					px = expand_pkg::pix_t'($signed(r[7:0]));
				end
				send_tap(layer, px, 1'b1);
			end
		end
	endtask

	// Ramp of plain pixels
	task automatic send_ramp(input logic layer, input int ntaps, input logic record);
		for (int t = 0; t < ntaps; t++) begin
			send_tap(layer, expand_pkg::pix_t'(t * 7 - 100), record);
		end
	endtask

	// Unrecorded taps on back to back cycles
	task automatic send_burst(input logic layer, input int ntaps);
		for (int t = 0; t < ntaps; t++) begin
			fire2_en <= !layer;
			fire3_en <= layer;
			pix <= expand_pkg::pix_t'(t * 7 - 100);
			@(posedge clk);
		end
	endtask

	// Wait for pending words, latency is 5 edges
	task automatic drain();
		int n;
		n = 0;
		fire2_en <= 1'b0;
		fire3_en <= 1'b0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected output words never arrived", exp_q.size());
			missing_errs += exp_q.size();
			exp_q.delete();
		end
		repeat (8) @(posedge clk);
	endtask

	task automatic pulse_ack(input logic layer);
		ram_ack2 <= !layer;
		ram_ack3 <= layer;
		@(posedge clk);
		ram_ack2 <= 1'b0;
		ram_ack3 <= 1'b0;
		@(posedge clk);
	endtask

	task automatic check_state(input logic exp_valid, input logic exp_f2, input logic exp_f3);
		@(negedge clk);
		check_flag("ofm_valid_o", ofm_valid, exp_valid);
		check_flag("finish2_o", finish2, exp_f2);
		check_flag("finish3_o", finish3, exp_f3);
		@(posedge clk);
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial begin
		apply_reset();
		check_state(1'b0, 1'b0, 1'b0);
		// fire2 layer, then extra taps that must be ignored
		run_layer(1'b0, expand_pkg::OUT_PIX);
		drain();
		check_state(1'b0, 1'b1, 1'b0);
		send_ramp(1'b0, expand_pkg::TAPS, 1'b0);
		drain();
		pulse_ack(1'b0);
		check_state(1'b0, 1'b0, 1'b0);
		// fire3 layer with its own tables
		run_layer(1'b1, expand_pkg::OUT_PIX);
		drain();
		check_state(1'b0, 1'b0, 1'b1);
		send_ramp(1'b1, expand_pkg::TAPS, 1'b0);
		drain();
		pulse_ack(1'b1);
		check_state(1'b0, 1'b0, 1'b0);
		// finish3 left high, fire2 stopped inside its fourth pixel
		// Third word still in the pipeline when reset hits
		apply_reset();
		run_layer(1'b1, expand_pkg::OUT_PIX);
		drain();
		run_layer(1'b0, 3);
		send_burst(1'b0, 3);
		apply_reset();
		check_state(1'b0, 1'b0, 1'b0);
		// Fresh fire2 layer from tap 0
		run_layer(1'b0, expand_pkg::OUT_PIX);
		drain();
		check_state(1'b0, 1'b1, 1'b0);
		$display("Errors: %0d wrong values, %0d unexpected outputs, %0d missing outputs",
			value_errs, unexpected_errs, missing_errs);
		if (value_errs + unexpected_errs + missing_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("Timeout after %0d cycles, the test sequence did not complete",
			WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
